// ==== build.f ====
rtl/video_pkg.sv
rtl/reg_decode.sv
rtl/line_timer.sv
rtl/palette_ram.sv
rtl/oam_dma.sv
rtl/lcd_status.sv
rtl/video.sv
tests/video_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       ?= video_tb
FILELIST  ?= build.f
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== tests/video_tb.sv ====
// stops at the first error; dma_data is modelled as the low address byte xor the page
module video_tb import video_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int line_dots    = 456;
	localparam int frame_lines  = 154;
	localparam int frame_cycles = line_dots * frame_lines;

	// registers that read back exactly what was written
	localparam logic [7:0] plain_regs [8] = '{addr_scy, addr_scx, addr_lyc, addr_bgp,
		addr_obp0, addr_obp1, addr_wy, addr_wx};
	// addresses outside the register map
	localparam logic [7:0] unmapped [6] = '{8'h00, 8'h3f, 8'h4c, 8'h67, 8'h6c, 8'hff};

	logic        clk_reg;
	logic        reset;
	logic        cgb;
	logic        cpu_sel_reg;
	logic        cpu_sel_oam;
	logic [7:0]  cpu_addr;
	logic        cpu_wr;
	logic [7:0]  cpu_di;
	logic [7:0]  cpu_do;
	logic        lcd_on;
	logic        irq;
	logic        vblank_irq;
	lcd_mode_t   mode;
	logic        dma_rd;
	logic [15:0] dma_addr;
	logic [7:0]  dma_data;

	integer      seed;
	// copies of what the cpu last wrote
	logic [3:0]  stat_sh;
	logic [7:0]  lyc_sh;
	logic [7:0]  scx_sh;

	video #(.oam_bytes(160)) dut (.*);

	// source memory with one byte per address
	assign dma_data = dma_addr[7:0] ^ dma_addr[15:8];

	initial clk_reg = 1'b0;
	always #2 clk_reg = ~clk_reg;

	// ------------------------------------------------------------------
	// error handling and cpu bus tasks
	// ------------------------------------------------------------------
	task automatic fail_now(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		assert (got == exp) else
			fail_now($sformatf("FAILED at %0t: %s = %0h, expected %0h", $time, name, got, exp));
	endtask

	// inputs change half a ns after the edge
	task automatic next_cycle();
		@(posedge clk_reg);
		#0.5;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
		next_cycle();
		cpu_sel_oam = 1'b0;
		cpu_sel_reg = 1'b1;
		cpu_wr      = 1'b1;
		cpu_addr    = addr;
		cpu_di      = data;
		next_cycle();
		cpu_sel_reg = 1'b0;
		cpu_wr      = 1'b0;
	endtask

	task automatic write_oam(input logic [7:0] addr, input logic [7:0] data);
		next_cycle();
		cpu_sel_oam = 1'b1;
		cpu_wr      = 1'b1;
		cpu_addr    = addr;
		cpu_di      = data;
		next_cycle();
		cpu_wr      = 1'b0;
	endtask

	// cpu_do is sampled mid cycle away from both edges
	task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
		next_cycle();
		cpu_sel_oam = 1'b0;
		cpu_addr    = addr;
		#1;
		data = cpu_do;
	endtask

	task automatic read_oam(input logic [7:0] addr, output logic [7:0] data);
		next_cycle();
		cpu_sel_oam = 1'b1;
		cpu_addr    = addr;
		#1;
		data = cpu_do;
	endtask

	task automatic check_reg(input logic [7:0] addr, input logic [7:0] exp, input string name);
		logic [7:0] got;
		read_reg(addr, got);
		check_value(name, got, exp);
	endtask

	task automatic set_stat(input logic [3:0] en);
		// enables sit in stat bits 6 to 3
		write_reg(addr_stat, {1'b0, en, 3'b000});
		stat_sh = en;
	endtask

	task automatic wait_mode(input lcd_mode_t want, input int limit);
		int n;
		n = 0;
		next_cycle();
		#1;
		while (mode != want) begin
			n++;
			if (n > limit)
				fail_now($sformatf("timeout while waiting for mode %s", want.name()));
			next_cycle();
			#1;
		end
	endtask

	// leaves cpu_addr on LY
	task automatic wait_ly(input logic [7:0] want, input int limit);
		logic [7:0] ly;
		int n;
		n = 0;
		read_reg(addr_ly, ly);
		while (ly != want) begin
			n++;
			if (n > limit)
				fail_now($sformatf("timeout while waiting for LY %0d", want));
			read_reg(addr_ly, ly);
		end
	endtask

	// ------------------------------------------------------------------
	// raster reference where dot 0 is the first cycle a new LY is visible
	// ------------------------------------------------------------------
	function automatic lcd_mode_t expected_mode(input int line, input int dot, input int extra);
		if (line <= 144 && dot < 4)
			return hblank;
		if (line >= 144)
			return vblank;
		if (dot <= 80)
			return oam_scan;
		if (dot < 256 + extra)
			return transfer;
		return hblank;
	endfunction

	// every source shows one dot after its cause
	function automatic logic expected_irq(input int line, input int dot, input int extra);
		logic hit;
		hit = 1'b0;
		if (stat_sh[3] && line == int'(lyc_sh) && dot == 1)
			hit = 1'b1;
		if (stat_sh[2] && dot == 1)
			hit = 1'b1;
		if (stat_sh[1] && line == 144 && dot == 0)
			hit = 1'b1;
		// hblank starts at 80 + 176 + extra
		if (stat_sh[0] && dot == 257 + extra)
			hit = 1'b1;
		return hit;
	endfunction

	// checks LY, mode and both interrupt lines on every cycle of one frame
	task automatic watch_frame();
		int line;
		int dot;
		int extra;
		extra   = (scx_sh[2:0] != 3'd0) ? 8 : 0;
		line    = 0;
		dot     = 0;
		wait_ly(8'd153, frame_cycles);
		wait_ly(8'd0, line_dots);
		for (int n = 0; n < frame_cycles; n++) begin
			check_value("ly", cpu_do, line);
			check_value("mode", mode, expected_mode(line, dot, extra));
			check_value("vblank_irq", vblank_irq, (line == 144 && dot == 0));
			check_value("irq", irq, expected_irq(line, dot, extra));
			dot++;
			if (dot == line_dots) begin
				dot  = 0;
				line = (line == 153) ? 0 : line + 1;
			end
			next_cycle();
			#1;
		end
		// one full frame later LY must have wrapped back to 0
		check_value("ly", cpu_do, 0);
	endtask

	// ------------------------------------------------------------------
	// test sequences
	// ------------------------------------------------------------------
	task automatic check_registers();
		logic [7:0] r;
		check_reg(addr_lcdc, 8'h00, "lcdc");
		check_reg(addr_bgp, 8'hfc, "bgp");
		check_reg(addr_obp0, 8'hff, "obp0");
		check_reg(addr_obp1, 8'hff, "obp1");
		for (int i = 0; i < 8; i++) begin
			r = 8'($random(seed));
			write_reg(plain_regs[i], r);
			if (plain_regs[i] == addr_lyc)
				lyc_sh = r;
			if (plain_regs[i] == addr_scx)
				scx_sh = r;
			check_reg(plain_regs[i], r, $sformatf("register %02h", plain_regs[i]));
		end
		// keep the display off here
		r = 8'($random(seed)) & 8'h7f;
		write_reg(addr_lcdc, r);
		check_reg(addr_lcdc, r, "lcdc");
		check_value("lcd_on", lcd_on, r[7]);
		// stat reads the fixed one, the enables, the LY match with LY at 0 and mode hblank
		r = 8'($random(seed));
		write_reg(addr_stat, r);
		stat_sh = r[6:3];
		check_reg(addr_stat, {1'b1, r[6:3], lyc_sh == 8'd0, 2'b00}, "stat");
		for (int i = 0; i < 6; i++)
			check_reg(unmapped[i], 8'hff, $sformatf("unmapped %02h", unmapped[i]));
	endtask

	task automatic check_lyc_write();
		logic [7:0] ly;
		int pulses;
		write_reg(addr_lyc, 8'd200);
		lyc_sh = 8'd200;
		set_stat(4'b1000);
		// mid line and far from dot 0
		wait_mode(oam_scan, frame_cycles);
		wait_mode(transfer, line_dots);
		read_reg(addr_ly, ly);
		write_reg(addr_lyc, ly);
		lyc_sh = ly;
		pulses = 0;
		for (int n = 0; n < 8; n++) begin
			next_cycle();
			#1;
			if (irq)
				pulses++;
		end
		check_value("irq pulses after lyc write", pulses, 1);
	endtask

	task automatic check_raster();
		write_reg(addr_scx, 8'h00);
		scx_sh = 8'h00;
		set_stat(4'b0000);
		write_reg(addr_lcdc, 8'h80);
		#1;
		check_value("lcd_on", lcd_on, 1);
		// irq must stay low with no enables
		watch_frame();
		write_reg(addr_scx, 8'h05);
		scx_sh = 8'h05;
		watch_frame();
		write_reg(addr_scx, 8'h00);
		scx_sh = 8'h00;
		write_reg(addr_lyc, 8'd10);
		lyc_sh = 8'd10;
		// one enable at a time
		for (int b = 0; b < 4; b++) begin
			set_stat(4'(1 << b));
			watch_frame();
		end
		check_lyc_write();
		set_stat(4'b0000);
	endtask

	task automatic check_dma();
		logic [7:0] page;
		logic [7:0] got;
		int count;
		page  = 8'($random(seed));
		count = 0;
		write_reg(addr_dma, page);
		#1;
		check_value("dma_rd", dma_rd, 1);
		while (dma_rd) begin
			check_value("dma_addr", dma_addr, (int'(page) << 8) | (count / 4));
			count++;
			if (count > 700)
				fail_now("timeout while waiting for dma_rd to fall");
			next_cycle();
			#1;
		end
		check_value("dma_rd cycles", count, 640);
		for (int i = 0; i < 160; i++) begin
			read_oam(8'(i), got);
			check_value($sformatf("oam[%0d]", i), got, 8'(i) ^ page);
		end
	endtask

	task automatic check_oam_blocking();
		logic [7:0] got;
		// entry order makes each wait start a fresh phase
		wait_mode(transfer, frame_cycles);
		wait_mode(hblank, line_dots);
		write_oam(8'd5, 8'h11);
		read_oam(8'd5, got);
		check_value("oam[5] after hblank write", got, 8'h11);
		wait_mode(oam_scan, frame_cycles);
		write_oam(8'd5, 8'h22);
		read_oam(8'd5, got);
		check_value("oam[5] after oam_scan write", got, 8'h11);
		wait_mode(transfer, line_dots);
		write_oam(8'd5, 8'h33);
		read_oam(8'd5, got);
		check_value("oam[5] after transfer write", got, 8'h11);
		wait_mode(hblank, line_dots);
		write_oam(8'd5, 8'h44);
		read_oam(8'd5, got);
		check_value("oam[5] after hblank write", got, 8'h44);
		wait_mode(vblank, frame_cycles);
		write_oam(8'd5, 8'h55);
		read_oam(8'd5, got);
		check_value("oam[5] after vblank write", got, 8'h55);
	endtask

	task automatic fill_palette(input logic [7:0] idx_addr, input logic [7:0] data_addr);
		logic [7:0] vals [10];
		// start near the top so the index wraps
		write_reg(idx_addr, 8'h80 | 8'd60);
		for (int i = 0; i < 10; i++) begin
			vals[i] = 8'($random(seed));
			write_reg(data_addr, vals[i]);
		end
		check_reg(idx_addr, 8'h86, "palette index");
		for (int i = 0; i < 10; i++) begin
			write_reg(idx_addr, 8'((60 + i) % 64));
			check_reg(data_addr, vals[i], $sformatf("palette byte %0d", (60 + i) % 64));
		end
	endtask

	task automatic check_palettes();
		next_cycle();
		cgb = 1'b1;
		// display off keeps the palettes open to the cpu
		write_reg(addr_lcdc, 8'h00);
		fill_palette(addr_bgpi, addr_bgpd);
		fill_palette(addr_obpi, addr_obpd);
		write_reg(addr_lcdc, 8'h80);
		wait_mode(transfer, frame_cycles);
		check_reg(addr_bgpd, 8'hff, "bg palette data in transfer");
		check_reg(addr_obpd, 8'hff, "obj palette data in transfer");
		next_cycle();
		cgb = 1'b0;
		for (int a = 8'h68; a <= 8'h6b; a++)
			check_reg(8'(a), 8'hff, $sformatf("palette port %02h without cgb", a));
	endtask

	// ------------------------------------------------------------------
	// checks that hold on every cycle
	// ------------------------------------------------------------------
	assert property (@(posedge clk_reg) disable iff (reset) vblank_irq |=> !vblank_irq)
		else fail_now("vblank_irq stayed high for more than one cycle");

	assert property (@(posedge clk_reg) disable iff (reset) !lcd_on |-> mode == hblank)
		else fail_now("mode was not hblank while the lcd was off");

	assert property (@(posedge clk_reg) disable iff (reset) $rose(dma_rd) |-> dma_addr[7:0] == 8'd0)
		else fail_now("dma did not start at the first byte of the page");

	initial begin
		reset       = 1'b1;
		cgb         = 1'b0;
		cpu_sel_reg = 1'b0;
		cpu_sel_oam = 1'b0;
		cpu_addr    = 8'h00;
		cpu_wr      = 1'b0;
		cpu_di      = 8'h00;
		seed        = 32'h442ff03a;
		stat_sh     = 4'h0;
		lyc_sh      = 8'h00;
		scx_sh      = 8'h00;
		repeat (2) next_cycle();
		reset = 1'b0;
		check_registers();
		check_raster();
		check_dma();
		check_oam_blocking();
		check_palettes();
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== rtl/video.sv ====
// register, timing and interrupt side only; dma_data must be valid combinationally for dma_addr
module video import video_pkg::*; #(
	parameter int oam_bytes = 160
) (
	input  logic        clk_reg,
	input  logic        reset,
	input  logic        cgb,
	input  logic        cpu_sel_reg,
	input  logic        cpu_sel_oam,
	input  logic [7:0]  cpu_addr,
	input  logic        cpu_wr,
	input  logic [7:0]  cpu_di,
	output logic [7:0]  cpu_do,
	output logic        lcd_on,
	output logic        irq,
	output logic        vblank_irq,
	output lcd_mode_t   mode,
	output logic        dma_rd,
	output logic [15:0] dma_addr,
	input  logic [7:0]  dma_data
);

	logic [7:0] lcdc;
	logic [3:0] stat_en;
	logic [7:0] scy;
	logic [7:0] scx;
	logic [7:0] lyc;
	logic [7:0] wy;
	logic [7:0] wx;
	logic [7:0] bgp;
	logic [7:0] obp0;
	logic [7:0] obp1;
	logic [7:0] dma_page;
	logic       dma_start;
	logic       lyc_written;
	logic       bg_idx_wr;
	logic       bg_data_wr;
	logic       obj_idx_wr;
	logic       obj_data_wr;
	logic [8:0] h_cnt;
	logic [7:0] v_cnt;
	logic [8:0] hblank_start;
	logic [7:0] oam_rdata;
	logic [7:0] bg_index_byte;
	logic [7:0] bg_data_rd;
	logic [7:0] obj_index_byte;
	logic [7:0] obj_data_rd;

	// lcdc bit 7 is the master display enable
	assign lcd_on = lcdc[7];

	// ------------------------------------------------------------------
	// decode
	// ------------------------------------------------------------------
	reg_decode u_decode (
		.clk_reg(clk_reg), .reset(reset), .cpu_sel_reg(cpu_sel_reg), .cpu_wr(cpu_wr),
		.cpu_addr(cpu_addr), .cpu_di(cpu_di), .lcdc(lcdc), .stat_en(stat_en),
		.scy(scy), .scx(scx), .lyc(lyc), .wy(wy), .wx(wx), .bgp(bgp),
		.obp0(obp0), .obp1(obp1), .dma_page(dma_page), .dma_start(dma_start),
		.lyc_written(lyc_written), .bg_idx_wr(bg_idx_wr), .bg_data_wr(bg_data_wr),
		.obj_idx_wr(obj_idx_wr), .obj_data_wr(obj_data_wr)
	);

	// ------------------------------------------------------------------
	// execute
	// ------------------------------------------------------------------
	line_timer u_timer (
		.clk_reg(clk_reg), .reset(reset), .lcd_on(lcd_on), .scx(scx),
		.h_cnt(h_cnt), .v_cnt(v_cnt), .mode(mode), .hblank_start(hblank_start)
	);

	oam_dma #(.oam_bytes(oam_bytes)) u_dma (
		.clk_reg(clk_reg), .reset(reset), .cpu_sel_oam(cpu_sel_oam), .cpu_wr(cpu_wr),
		.cpu_addr(cpu_addr), .cpu_di(cpu_di), .mode(mode), .dma_start(dma_start),
		.dma_page(dma_page), .dma_data(dma_data), .dma_rd(dma_rd),
		.dma_addr(dma_addr), .oam_rdata(oam_rdata)
	);

	// background and sprite colour palettes
	palette_ram bg_pal (
		.clk_reg(clk_reg), .reset(reset), .idx_wr(bg_idx_wr), .data_wr(bg_data_wr),
		.cpu_di(cpu_di), .mode(mode), .index_byte(bg_index_byte), .data_rd(bg_data_rd)
	);

	palette_ram obj_pal (
		.clk_reg(clk_reg), .reset(reset), .idx_wr(obj_idx_wr), .data_wr(obj_data_wr),
		.cpu_di(cpu_di), .mode(mode), .index_byte(obj_index_byte), .data_rd(obj_data_rd)
	);

	// ------------------------------------------------------------------
	// result
	// ------------------------------------------------------------------
	lcd_status u_status (
		.clk_reg(clk_reg), .reset(reset), .cgb(cgb), .cpu_sel_oam(cpu_sel_oam),
		.cpu_addr(cpu_addr), .oam_rdata(oam_rdata), .lcdc(lcdc), .stat_en(stat_en),
		.scy(scy), .scx(scx), .lyc(lyc), .wy(wy), .wx(wx), .bgp(bgp), .obp0(obp0),
		.obp1(obp1), .dma_page(dma_page), .lyc_written(lyc_written), .h_cnt(h_cnt),
		.v_cnt(v_cnt), .mode(mode), .hblank_start(hblank_start),
		.bg_index_byte(bg_index_byte), .bg_data_rd(bg_data_rd),
		.obj_index_byte(obj_index_byte), .obj_data_rd(obj_data_rd),
		.irq(irq), .vblank_irq(vblank_irq), .cpu_do(cpu_do)
	);

endmodule

// ==== rtl/lcd_status.sv ====
// irq and vblank_irq are one-cycle pulses one clock after their cause; cpu_do is combinational
module lcd_status import video_pkg::*; (
	input  logic       clk_reg,
	input  logic       reset,
	input  logic       cgb,
	input  logic       cpu_sel_oam,
	input  logic [7:0] cpu_addr,
	input  logic [7:0] oam_rdata,
	input  logic [7:0] lcdc,
	input  logic [3:0] stat_en,
	input  logic [7:0] scy,
	input  logic [7:0] scx,
	input  logic [7:0] lyc,
	input  logic [7:0] wy,
	input  logic [7:0] wx,
	input  logic [7:0] bgp,
	input  logic [7:0] obp0,
	input  logic [7:0] obp1,
	input  logic [7:0] dma_page,
	input  logic       lyc_written,
	input  logic [8:0] h_cnt,
	input  logic [7:0] v_cnt,
	input  lcd_mode_t  mode,
	input  logic [8:0] hblank_start,
	input  logic [7:0] bg_index_byte,
	input  logic [7:0] bg_data_rd,
	input  logic [7:0] obj_index_byte,
	input  logic [7:0] obj_data_rd,
	output logic       irq,
	output logic       vblank_irq,
	output logic [7:0] cpu_do
);

	logic lyc_match;
	logic lyc_wr_d;
	logic irq_next;
	logic vblank_next;

	assign lyc_match = (v_cnt == lyc);
	// last dot of the last visible line
	assign vblank_next = (h_cnt == line_last) && (v_cnt == visible_lines - 8'd1);

	// ------------------------------------------------------------------
	// stat interrupt sources
	// ------------------------------------------------------------------
	always_comb begin
		irq_next = 1'b0;
		// ly match at the start of the line
		if (stat_en[3] && lyc_match && (h_cnt == 9'd0))
			irq_next = 1'b1;
		// match created by a fresh lyc write mid line
		if (stat_en[3] && lyc_match && (h_cnt != 9'd0) && lyc_wr_d)
			irq_next = 1'b1;
		if (stat_en[2] && (h_cnt == 9'd0))
			irq_next = 1'b1;
		if (stat_en[1] && vblank_next)
			irq_next = 1'b1;
		if (stat_en[0] && (h_cnt == hblank_start))
			irq_next = 1'b1;
	end

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			irq        <= 1'b0;
			vblank_irq <= 1'b0;
			lyc_wr_d   <= 1'b0;
		end else begin
			irq        <= irq_next;
			vblank_irq <= vblank_next;
			lyc_wr_d   <= lyc_written;
		end
	end

	// ------------------------------------------------------------------
	// cpu readback
	// ------------------------------------------------------------------
	always_comb begin
		if (cpu_sel_oam) begin
			cpu_do = oam_rdata;
		end else begin
			case (cpu_addr)
				addr_lcdc: cpu_do = lcdc;
				// bit 7 always reads as one
				addr_stat: cpu_do = {1'b1, stat_en, lyc_match, mode};
				addr_scy:  cpu_do = scy;
				addr_scx:  cpu_do = scx;
				addr_ly:   cpu_do = v_cnt;
				addr_lyc:  cpu_do = lyc;
				addr_dma:  cpu_do = dma_page;
				addr_bgp:  cpu_do = bgp;
				addr_obp0: cpu_do = obp0;
				addr_obp1: cpu_do = obp1;
				addr_wy:   cpu_do = wy;
				addr_wx:   cpu_do = wx;
				// colour palettes are hidden in mono mode
				addr_bgpi: cpu_do = cgb ? bg_index_byte : 8'hff;
				addr_bgpd: cpu_do = cgb ? bg_data_rd : 8'hff;
				addr_obpi: cpu_do = cgb ? obj_index_byte : 8'hff;
				addr_obpd: cpu_do = cgb ? obj_data_rd : 8'hff;
				default:   cpu_do = 8'hff;
			endcase
		end
	end

endmodule

// ==== rtl/oam_dma.sv ====
// oam_bytes up to 256; dma takes four cycles per byte and blocks cpu oam writes meanwhile
module oam_dma import video_pkg::*; #(
	parameter int oam_bytes = 160
) (
	input  logic        clk_reg,
	input  logic        reset,
	input  logic        cpu_sel_oam,
	input  logic        cpu_wr,
	input  logic [7:0]  cpu_addr,
	input  logic [7:0]  cpu_di,
	input  lcd_mode_t   mode,
	input  logic        dma_start,
	input  logic [7:0]  dma_page,
	input  logic [7:0]  dma_data,
	output logic        dma_rd,
	output logic [15:0] dma_addr,
	output logic [7:0]  oam_rdata
);

	localparam logic [9:0] dma_last = 10'(4 * oam_bytes - 1);

	logic [7:0] oam [oam_bytes];
	logic [9:0] dma_cnt;
	logic [7:0] oam_idx;
	logic [7:0] oam_wdata;
	logic       oam_we;
	logic       cpu_ok;

	// ------------------------------------------------------------------
	// dma step counter
	// ------------------------------------------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			dma_rd  <= 1'b0;
			dma_cnt <= 10'd0;
		end else if (dma_start) begin
			// a new write restarts the copy from byte 0
			dma_rd  <= 1'b1;
			dma_cnt <= 10'd0;
		end else if (dma_rd) begin
			if (dma_cnt == dma_last)
				dma_rd <= 1'b0;
			else
				dma_cnt <= dma_cnt + 10'd1;
		end
	end

	// source byte index is the step count over four
	assign dma_addr = {dma_page, dma_cnt[9:2]};

	// oam is locked to the cpu while sprites are being scanned or drawn
	assign cpu_ok    = (mode != oam_scan) && (mode != transfer);
	assign oam_idx   = dma_rd ? dma_cnt[9:2] : cpu_addr;
	// source data is taken in the middle of each four-cycle step
	assign oam_we    = dma_rd ? (dma_cnt[1:0] == 2'd2) : (cpu_sel_oam && cpu_wr && cpu_ok);
	assign oam_wdata = dma_rd ? dma_data : cpu_di;

	always_ff @(posedge clk_reg) begin
		if (oam_we && (oam_idx < oam_bytes))
			oam[oam_idx] <= oam_wdata;
	end

	// bytes past the end of oam read as open bus
	assign oam_rdata = (cpu_addr < oam_bytes) ? oam[cpu_addr] : 8'hff;

endmodule

// ==== rtl/palette_ram.sv ====
// one 64-byte colour palette; data writes are dropped while the mode is transfer
module palette_ram import video_pkg::*; (
	input  logic       clk_reg,
	input  logic       reset,
	input  logic       idx_wr,
	input  logic       data_wr,
	input  logic [7:0] cpu_di,
	input  lcd_mode_t  mode,
	output logic [7:0] index_byte,
	output logic [7:0] data_rd
);

	localparam int depth = 1 << pal_addr_w;

	logic [7:0]            mem [depth];
	logic [pal_addr_w-1:0] idx;
	logic                  auto_inc;
	logic                  busy;

	// the pixel path owns the palette during transfer
	assign busy = (mode == transfer);

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			idx      <= '0;
			auto_inc <= 1'b0;
			for (int i = 0; i < depth; i++)
				mem[i] <= 8'h00;
		end else if (idx_wr) begin
			idx      <= cpu_di[pal_addr_w-1:0];
			auto_inc <= cpu_di[7];
		end else if (data_wr && !busy) begin
			mem[idx] <= cpu_di;
			// index wraps at 64 by its width
			if (auto_inc)
				idx <= idx + 1'b1;
		end
	end

	// flag, one zero bit, then the index
	assign index_byte = {auto_inc, 1'b0, idx};
	assign data_rd    = busy ? 8'hff : mem[idx];

endmodule

// ==== rtl/line_timer.sv ====
// counters advance once per clk_reg cycle; mode-3 length follows fine x scroll only
module line_timer import video_pkg::*; (
	input  logic       clk_reg,
	input  logic       reset,
	input  logic       lcd_on,
	input  logic [7:0] scx,
	output logic [8:0] h_cnt,
	output logic [7:0] v_cnt,
	output lcd_mode_t  mode,
	output logic [8:0] hblank_start
);

	// fine scroll, held stable for the rest of the line
	logic [2:0] fine_x;
	logic [8:0] extra;

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			h_cnt  <= lcd_off_dot;
			v_cnt  <= 8'd0;
			fine_x <= 3'd0;
		end else if (!lcd_on) begin
			// counters park while the lcd is off
			h_cnt <= lcd_off_dot;
			v_cnt <= 8'd0;
		end else begin
			// latch just before pixel output would start
			if (h_cnt == scroll_latch_dot)
				fine_x <= scx[2:0];
			if (h_cnt == line_last) begin
				h_cnt <= 9'd0;
				// wrap to line 0 after the last vblank line
				if (v_cnt == frame_last)
					v_cnt <= 8'd0;
				else
					v_cnt <= v_cnt + 8'd1;
			end else begin
				h_cnt <= h_cnt + 9'd1;
			end
		end
	end

	// a partial first tile costs one more fetch of 8 dots
	assign extra        = (fine_x != 3'd0) ? 9'd8 : 9'd0;
	assign hblank_start = oam_scan_len + mode3_base + extra;

	// ------------------------------------------------------------------
	// stat mode, first matching rule wins
	// ------------------------------------------------------------------
	always_comb begin
		if (!lcd_on)
			mode = hblank;
		else if ((v_cnt <= visible_lines) && (h_cnt < 9'd4))
			mode = hblank;
		else if (v_cnt >= visible_lines)
			mode = vblank;
		else if (h_cnt <= oam_scan_len)
			mode = oam_scan;
		else if (h_cnt < hblank_start)
			mode = transfer;
		else
			mode = hblank;
	end

endmodule

// ==== rtl/reg_decode.sv ====
// writes need cpu_sel_reg and cpu_wr high for one clk_reg edge; pulses are combinational
module reg_decode import video_pkg::*; (
	input  logic       clk_reg,
	input  logic       reset,
	input  logic       cpu_sel_reg,
	input  logic       cpu_wr,
	input  logic [7:0] cpu_addr,
	input  logic [7:0] cpu_di,
	output logic [7:0] lcdc,
	output logic [3:0] stat_en,
	output logic [7:0] scy,
	output logic [7:0] scx,
	output logic [7:0] lyc,
	output logic [7:0] wy,
	output logic [7:0] wx,
	output logic [7:0] bgp,
	output logic [7:0] obp0,
	output logic [7:0] obp1,
	output logic [7:0] dma_page,
	output logic       dma_start,
	output logic       lyc_written,
	output logic       bg_idx_wr,
	output logic       bg_data_wr,
	output logic       obj_idx_wr,
	output logic       obj_data_wr
);

	logic wr_en;

	assign wr_en = cpu_sel_reg && cpu_wr;

	// one cycle strobes, same cycle as the write itself
	assign dma_start   = wr_en && (cpu_addr == addr_dma);
	assign lyc_written = wr_en && (cpu_addr == addr_lyc);
	assign bg_idx_wr   = wr_en && (cpu_addr == addr_bgpi);
	assign bg_data_wr  = wr_en && (cpu_addr == addr_bgpd);
	assign obj_idx_wr  = wr_en && (cpu_addr == addr_obpi);
	assign obj_data_wr = wr_en && (cpu_addr == addr_obpd);

	// ------------------------------------------------------------------
	// plain register file
	// ------------------------------------------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			// lcd starts switched off
			lcdc     <= 8'h00;
			stat_en  <= 4'h0;
			scy      <= 8'h00;
			scx      <= 8'h00;
			lyc      <= 8'h00;
			wy       <= 8'h00;
			wx       <= 8'h00;
			bgp      <= 8'hfc;
			obp0     <= 8'hff;
			obp1     <= 8'hff;
			dma_page <= 8'h00;
		end else if (wr_en) begin
			case (cpu_addr)
				addr_lcdc: lcdc <= cpu_di;
				// only the four interrupt enables are writable in stat
				addr_stat: stat_en <= cpu_di[6:3];
				addr_scy:  scy <= cpu_di;
				addr_scx:  scx <= cpu_di;
				addr_lyc:  lyc <= cpu_di;
				addr_dma:  dma_page <= cpu_di;
				addr_bgp:  bgp <= cpu_di;
				addr_obp0: obp0 <= cpu_di;
				addr_obp1: obp1 <= cpu_di;
				addr_wy:   wy <= cpu_di;
				addr_wx:   wx <= cpu_di;
				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/video_pkg.sv ====
// addresses are the low byte of the io page and every timing count is in clk_reg cycles
package video_pkg;

	// ------------------------------------------------------------------
	// cpu register map
	// ------------------------------------------------------------------
	localparam logic [7:0] addr_lcdc = 8'h40;
	localparam logic [7:0] addr_stat = 8'h41;
	localparam logic [7:0] addr_scy  = 8'h42;
	localparam logic [7:0] addr_scx  = 8'h43;
	localparam logic [7:0] addr_ly   = 8'h44;
	localparam logic [7:0] addr_lyc  = 8'h45;
	localparam logic [7:0] addr_dma  = 8'h46;
	localparam logic [7:0] addr_bgp  = 8'h47;
	localparam logic [7:0] addr_obp0 = 8'h48;
	localparam logic [7:0] addr_obp1 = 8'h49;
	localparam logic [7:0] addr_wy   = 8'h4a;
	localparam logic [7:0] addr_wx   = 8'h4b;
	// colour mode palette ports
	localparam logic [7:0] addr_bgpi = 8'h68;
	localparam logic [7:0] addr_bgpd = 8'h69;
	localparam logic [7:0] addr_obpi = 8'h6a;
	localparam logic [7:0] addr_obpd = 8'h6b;

	// ------------------------------------------------------------------
	// raster timing
	// ------------------------------------------------------------------
	localparam logic [8:0] line_last        = 9'd455;
	localparam logic [7:0] frame_last       = 8'd153;
	localparam logic [7:0] visible_lines    = 8'd144;
	localparam logic [8:0] oam_scan_len     = 9'd80;
	// 160 visible dots plus the fixed fetch offset
	localparam logic [8:0] mode3_base       = 9'd176;
	localparam logic [8:0] scroll_latch_dot = 9'd87;
	// dot count parked here while the lcd is off
	localparam logic [8:0] lcd_off_dot      = 9'd6;

	localparam int pal_addr_w = 6;

	// stat mode field, encoding as seen by the cpu
	typedef enum logic [1:0] {
		hblank   = 2'd0,
		vblank   = 2'd1,
		oam_scan = 2'd2,
		transfer = 2'd3
	} lcd_mode_t;

endpackage
